// File: source/sifhCfgPkg.sv
//**************************************************
// SiFH configuration
// sizing of timestamps, histogram bins, pixels and
// acquisition counts, plus sequencer phase codes
//**************************************************

package sifhCfgPkg;

    // timestamp and coarse bin widths
    localparam int Np = 8;
    localparam int Nb = 4;
    localparam int BIN_NUM = 2 ** Nb;

    // frame geometry
    localparam int PIXEL_NUM = 4;
    localparam int DATA_NUM = 4;
    localparam int ACQ_NUM = 8;

    // saturating bin counters
    localparam int CNT_W = 8;

    // derived widths
    localparam int PIX_W = $clog2(PIXEL_NUM);
    localparam int ADDR_W = PIX_W + Nb;
    localparam int DATA_W = $clog2(DATA_NUM);
    localparam int ACQ_W = $clog2(ACQ_NUM);

    // highest fine window lower edge
    localparam int WIN_MAX = 2 ** Np - 2 ** Nb;

    // sequencer phases
    localparam logic [2:0] PH_RUN = 3'd0;
    localparam logic [2:0] PH_FLUSH = 3'd1;
    localparam logic [2:0] PH_SCAN = 3'd2;
    localparam logic [2:0] PH_LOAD = 3'd3;
    localparam logic [2:0] PH_CLEAR = 3'd4;

endpackage

// File: source/sifhTypesPkg.sv
//**************************************************
// SiFH data types
// one sample word, seen as a raw timestamp or as a
// coarse bin with its fine remainder
//**************************************************

package sifhTypesPkg;
    import sifhCfgPkg::*;

    // raw view for window compare, split view for coarse binning
    typedef union packed {
        logic [Np-1:0] raw;
        struct packed {
            logic [Nb-1:0] coarse;
            logic [Np-Nb-1:0] fine;
        } split;
    } sampleWord_u;

endpackage

// File: source/sampleFilter.sv
//**************************************************
// sample filter
// maps each accepted timestamp to a histogram
// address, drops fine-pass samples off the window
//**************************************************

`timescale 1ns/1ps

module sampleFilter import sifhCfgPkg::*, sifhTypesPkg::*; (
    input  logic              clk,
    input  logic              combin_res,
    input  logic              sampleStrobe,
    input  logic              finePass,
    input  sampleWord_u       data,
    input  logic [PIX_W-1:0]  pixelIdx,
    input  logic [Np-1:0]     windowLo,
    output logic              binWrite,
    output logic [ADDR_W-1:0] binAddr
);

    logic [Np-1:0] offset;
    logic          inWindow;
    logic [Nb-1:0] binSel;

    // distance above the window edge, wraps below it
    assign offset = data.raw - windowLo;
    assign inWindow = (data.raw >= windowLo) && (offset < BIN_NUM);

    // coarse pass takes the top bits as is
    assign binSel = finePass ? offset[Nb-1:0] : data.split.coarse;

    // write strobe, dropped when off window
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binWrite <= 1'b0;
        end else begin
            binWrite <= sampleStrobe && (!finePass || inWindow);
        end
    end

    // pixel in the upper address bits
    always_ff @(posedge clk) begin
        binAddr <= {pixelIdx, binSel};
    end

endmodule

// File: source/histBuilder.sv
//**************************************************
// histogram builder
// per-pixel saturating bin counters with valid bits
// so a whole pass clears in one cycle
//**************************************************

`timescale 1ns/1ps

module histBuilder import sifhCfgPkg::*; (
    input  logic              clk,
    input  logic              combin_res,
    input  logic              binWrite,
    input  logic              histClear,
    input  logic [ADDR_W-1:0] binAddr,
    input  logic [ADDR_W-1:0] scanAddr,
    output logic [CNT_W-1:0]  scanCount
);

    logic [CNT_W-1:0]     binMem [2**ADDR_W];
    logic [2**ADDR_W-1:0] validBits;

    // write stage
    logic                 wrPend;
    logic [ADDR_W-1:0]    wrAddr;
    logic [CNT_W-1:0]     rdCount;
    logic [CNT_W-1:0]     newCount;
    logic [CNT_W-1:0]     memRead;

    //**************************************************
    // read side of the read-modify-write
    //**************************************************

    // a bin with its valid bit down reads as empty
    assign memRead = validBits[binAddr] ? binMem[binAddr] : '0;

    // saturate at all ones
    assign newCount = (&rdCount) ? rdCount : rdCount + 1'b1;

    always_ff @(posedge clk) begin
        wrAddr <= binAddr;
        // same bin hit twice in a row, take the value being written
        if (wrPend && (wrAddr == binAddr)) begin
            rdCount <= newCount;
        end else begin
            rdCount <= memRead;
        end
    end

    //**************************************************
    // write side and scan port
    //**************************************************

    always_ff @(posedge clk) begin
        if (wrPend) begin
            binMem[wrAddr] <= newCount;
        end
        scanCount <= validBits[scanAddr] ? binMem[scanAddr] : '0;
    end

    // valid bits and write pending
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            wrPend <= 1'b0;
            validBits <= '0;
        end else begin
            wrPend <= binWrite;
            if (histClear) begin
                validBits <= '0;
            end else if (wrPend) begin
                validBits[wrAddr] <= 1'b1;
            end
        end
    end

    // clear only comes between passes
    assert property (@(posedge clk) disable iff (!combin_res)
        histClear |-> !binWrite && !wrPend);

    // scanner walks the address only when no sample is in flight
    assert property (@(posedge clk) disable iff (!combin_res)
        wrPend |-> $stable(scanAddr));

endmodule

// File: source/peakScanner.sv
//**************************************************
// peak scanner
// walks every bin after a pass, keeps each pixel's
// first maximum so the lowest bin wins a tie
//**************************************************

`timescale 1ns/1ps

module peakScanner import sifhCfgPkg::*; (
    input  logic              clk,
    input  logic              combin_res,
    input  logic              scanStart,
    input  logic [CNT_W-1:0]  scanCount,
    output logic [ADDR_W-1:0] scanAddr,
    output logic [Nb-1:0]     peakBin,
    output logic [PIX_W-1:0]  peakPixel,
    output logic              peakWrite,
    output logic              scanDone
);

    logic              scanActive;
    logic              rdValid;
    logic [ADDR_W-1:0] rdAddr;
    logic [CNT_W-1:0]  maxCount;
    logic [Nb-1:0]     maxBin;
    logic [CNT_W-1:0]  curMax;
    logic [Nb-1:0]     curBin;

    // running maximum, restarted at bin 0 of each pixel
    always_comb begin
        curMax = maxCount;
        curBin = maxBin;
        if (rdAddr[Nb-1:0] == '0) begin
            curMax = scanCount;
            curBin = '0;
        end else if (scanCount > maxCount) begin
            curMax = scanCount;
            curBin = rdAddr[Nb-1:0];
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            scanActive <= 1'b0;
            scanAddr <= '0;
            rdValid <= 1'b0;
            peakWrite <= 1'b0;
            scanDone <= 1'b0;
        end else begin
            // address walk, one bin per cycle
            if (scanStart) begin
                scanActive <= 1'b1;
                scanAddr <= '0;
            end else if (scanActive) begin
                scanAddr <= scanAddr + 1'b1;
                scanActive <= !(&scanAddr);
            end
            // count comes back one cycle later
            rdValid <= scanActive;
            peakWrite <= rdValid && (&rdAddr[Nb-1:0]);
            scanDone <= rdValid && (&rdAddr);
        end
    end

    // payload follows the walk
    always_ff @(posedge clk) begin
        rdAddr <= scanAddr;
        if (rdValid) begin
            maxCount <= curMax;
            maxBin <= curBin;
            peakBin <= curBin;
            peakPixel <= rdAddr[ADDR_W-1:Nb];
        end
    end

endmodule

// File: source/windowCalc.sv
//**************************************************
// window calculator
// coarse peaks to clamped fine window edges,
// fine peaks to final per-pixel times
//**************************************************

`timescale 1ns/1ps

module windowCalc import sifhCfgPkg::*; (
    input  logic                      clk,
    input  logic                      combin_res,
    input  logic                      peakWrite,
    input  logic                      windowLoad,
    input  logic                      finePass,
    input  logic                      scanDone,
    input  logic [Nb-1:0]             peakBin,
    input  logic [PIX_W-1:0]          peakPixel,
    input  logic [PIX_W-1:0]          pixelIdx,
    output logic [Np-1:0]             windowLo,
    output logic [PIXEL_NUM*Np-1:0]   peakTimes,
    output logic                      resultValid
);

    logic [Np-1:0]           activeLo [PIXEL_NUM];
    logic [Np-1:0]           stagedLo [PIXEL_NUM];
    logic [Nb-1:0]           fineBin [PIXEL_NUM];
    logic signed [Np+1:0]    edgeRaw;
    logic [Np-1:0]           edgeNext;
    logic [PIXEL_NUM*Np-1:0] timesNext;

    //**************************************************
    // edge from coarse peak
    //**************************************************

    // bin centre minus half a fine window
    always_comb begin
        edgeRaw = $signed({2'b00, peakBin, {(Np - Nb){1'b0}}})
            + (Np + 2)'(2 ** (Np - Nb - 1) - BIN_NUM / 2);
        if (edgeRaw < 0) begin
            edgeNext = '0;
        end else if (edgeRaw > (Np + 2)'(WIN_MAX)) begin
            edgeNext = Np'(WIN_MAX);
        end else begin
            edgeNext = edgeRaw[Np-1:0];
        end
    end

    // last pixel's peak lands with scanDone
    always_comb begin
        for (int p = 0; p < PIXEL_NUM; p++) begin
            if (peakWrite && (peakPixel == PIX_W'(p))) begin
                timesNext[p*Np +: Np] = activeLo[p] + Np'(peakBin);
            end else begin
                timesNext[p*Np +: Np] = activeLo[p] + Np'(fineBin[p]);
            end
        end
    end

    assign windowLo = activeLo[pixelIdx];

    //**************************************************
    // staging and result registers
    //**************************************************

    always_ff @(posedge clk) begin
        if (peakWrite) begin
            if (finePass) begin
                fineBin[peakPixel] <= peakBin;
            end else begin
                stagedLo[peakPixel] <= edgeNext;
            end
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            activeLo <= '{default: '0};
            peakTimes <= '0;
            resultValid <= 1'b0;
        end else begin
            // new edges go live between passes
            if (windowLoad) begin
                activeLo <= stagedLo;
            end
            resultValid <= scanDone && finePass;
            if (scanDone && finePass) begin
                peakTimes <= timesNext;
            end
        end
    end

    // fine window must fit below the timestamp range
    assert property (@(posedge clk) disable iff (!combin_res)
        windowLo <= Np'(WIN_MAX));

endmodule

// File: source/frameSequencer.sv
//**************************************************
// frame sequencer
// counts samples, pixels and acquisitions, then
// runs scan, load and clear between passes
//**************************************************

`timescale 1ns/1ps

module frameSequencer import sifhCfgPkg::*; (
    input  logic             clk,
    input  logic             combin_res,
    input  logic             wrEn,
    input  logic             scanDone,
    output logic             sampleStrobe,
    output logic [PIX_W-1:0] pixelIdx,
    output logic             finePass,
    output logic             scanStart,
    output logic             histClear,
    output logic             windowLoad,
    output logic             busy
);

    logic [2:0]        phase;
    logic [DATA_W-1:0] sampleCnt;
    logic [ACQ_W-1:0]  acqCnt;
    logic              lastSample;
    logic              lastPixel;
    logic              lastAcq;

    // source pauses while busy
    assign sampleStrobe = wrEn && !busy;

    assign lastSample = sampleCnt == DATA_W'(DATA_NUM - 1);
    assign lastPixel = pixelIdx == PIX_W'(PIXEL_NUM - 1);
    assign lastAcq = acqCnt == ACQ_W'(ACQ_NUM - 1);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            phase <= PH_RUN;
            sampleCnt <= '0;
            pixelIdx <= '0;
            acqCnt <= '0;
            finePass <= 1'b0;
            scanStart <= 1'b0;
            histClear <= 1'b0;
            windowLoad <= 1'b0;
            busy <= 1'b0;
        end else begin
            // one-cycle pulses
            scanStart <= 1'b0;
            histClear <= 1'b0;
            windowLoad <= 1'b0;
            case (phase)
                PH_RUN: begin
                    if (sampleStrobe) begin
                        sampleCnt <= lastSample ? '0 : sampleCnt + 1'b1;
                        if (lastSample) begin
                            pixelIdx <= lastPixel ? '0 : pixelIdx + 1'b1;
                            if (lastPixel) begin
                                acqCnt <= lastAcq ? '0 : acqCnt + 1'b1;
                                // pass complete
                                if (lastAcq) begin
                                    phase <= PH_FLUSH;
                                    busy <= 1'b1;
                                end
                            end
                        end
                    end
                end
                // let the last write land before scanning
                PH_FLUSH: begin
                    scanStart <= 1'b1;
                    phase <= PH_SCAN;
                end
                PH_SCAN: begin
                    if (scanDone) begin
                        windowLoad <= !finePass;
                        phase <= PH_LOAD;
                    end
                end
                PH_LOAD: begin
                    histClear <= 1'b1;
                    phase <= PH_CLEAR;
                end
                PH_CLEAR: begin
                    busy <= 1'b0;
                    finePass <= !finePass;
                    phase <= PH_RUN;
                end
                default: phase <= PH_RUN;
            endcase
        end
    end

    // samples only enter during the run phase
    assert property (@(posedge clk) disable iff (!combin_res)
        sampleStrobe |-> phase == PH_RUN);

endmodule

// File: source/sifhTop.sv
//**************************************************
// SiFH two-pass peak finder
// coarse then fine per-pixel timestamp histograms
//**************************************************

`timescale 1ns/1ps

module sifhTop import sifhCfgPkg::*; (
    input  logic                    clk,
    input  logic                    combin_res,
    input  logic                    wrEn,
    input  logic [Np-1:0]           data,
    output logic                    busy,
    output logic [PIXEL_NUM*Np-1:0] peakTimes,
    output logic                    resultValid
);

    // sequencer controls
    logic              sampleStrobe;
    logic [PIX_W-1:0]  pixelIdx;
    logic              finePass;
    logic              scanStart;
    logic              histClear;
    logic              windowLoad;

    // datapath
    logic              binWrite;
    logic [ADDR_W-1:0] binAddr;
    logic [ADDR_W-1:0] scanAddr;
    logic [CNT_W-1:0]  scanCount;
    logic [Nb-1:0]     peakBin;
    logic [PIX_W-1:0]  peakPixel;
    logic              peakWrite;
    logic              scanDone;
    logic [Np-1:0]     windowLo;

    frameSequencer uSeq (
        .clk(clk), .combin_res(combin_res), .wrEn(wrEn), .scanDone(scanDone),
        .sampleStrobe(sampleStrobe), .pixelIdx(pixelIdx), .finePass(finePass),
        .scanStart(scanStart), .histClear(histClear), .windowLoad(windowLoad),
        .busy(busy)
    );

    sampleFilter uFilter (
        .clk(clk), .combin_res(combin_res), .sampleStrobe(sampleStrobe),
        .finePass(finePass), .data(data), .pixelIdx(pixelIdx),
        .windowLo(windowLo), .binWrite(binWrite), .binAddr(binAddr)
    );

    histBuilder uHist (
        .clk(clk), .combin_res(combin_res), .binWrite(binWrite),
        .histClear(histClear), .binAddr(binAddr), .scanAddr(scanAddr),
        .scanCount(scanCount)
    );

    peakScanner uScan (
        .clk(clk), .combin_res(combin_res), .scanStart(scanStart),
        .scanCount(scanCount), .scanAddr(scanAddr), .peakBin(peakBin),
        .peakPixel(peakPixel), .peakWrite(peakWrite), .scanDone(scanDone)
    );

    windowCalc uWin (
        .clk(clk), .combin_res(combin_res), .peakWrite(peakWrite),
        .windowLoad(windowLoad), .finePass(finePass), .scanDone(scanDone),
        .peakBin(peakBin), .peakPixel(peakPixel), .pixelIdx(pixelIdx),
        .windowLo(windowLo), .peakTimes(peakTimes), .resultValid(resultValid)
    );

endmodule

// File: bench/sifhModel.svh
//**************************************************
// SiFH reference model
// coarse and fine binning, first-maximum peak choice
// and clamped window edges, for the testbench
//**************************************************

`ifndef SIFH_MODEL_SVH
`define SIFH_MODEL_SVH

// samples in one pass, pixel-major inside each acquisition
localparam int PASS_LEN = ACQ_NUM * PIXEL_NUM * DATA_NUM;

logic [Np-1:0] coarseSamples [PASS_LEN];
logic [Np-1:0] fineSamples [PASS_LEN];
int            histModel [PIXEL_NUM][BIN_NUM];
logic [Np-1:0] edgeModel [PIXEL_NUM];
logic [Np-1:0] timeModel [PIXEL_NUM];

// DATA_NUM samples per pixel, then the next pixel
function automatic int samplePixel(input int idx);
    return (idx / DATA_NUM) % PIXEL_NUM;
endfunction

task automatic clearHist();
    for (int p = 0; p < PIXEL_NUM; p++) begin
        for (int b = 0; b < BIN_NUM; b++) begin
            histModel[p][b] = 0;
        end
    end
endtask

// counters stop at all ones
task automatic addHit(input int pix, input int bin);
    if (histModel[pix][bin] < 2 ** CNT_W - 1) begin
        histModel[pix][bin]++;
    end
endtask

// only a strictly greater count moves the peak
function automatic int firstPeak(input int pix);
    int best;
    best = 0;
    for (int b = 1; b < BIN_NUM; b++) begin
        if (histModel[pix][b] > histModel[pix][best]) begin
            best = b;
        end
    end
    return best;
endfunction

// coarse bin centre, half a fine window down, then clamp
function automatic logic [Np-1:0] windowEdge(input int bin);
    int lo;
    lo = bin * 2 ** (Np - Nb) + 2 ** (Np - Nb - 1) - BIN_NUM / 2;
    if (lo < 0) begin
        lo = 0;
    end
    if (lo > WIN_MAX) begin
        lo = WIN_MAX;
    end
    return Np'(lo);
endfunction

//**************************************************
// pass models
//**************************************************

task automatic modelCoarse();
    sampleWord_u w;
    clearHist();
    for (int i = 0; i < PASS_LEN; i++) begin
        w.raw = coarseSamples[i];
        addHit(samplePixel(i), int'(w.split.coarse));
    end
    for (int p = 0; p < PIXEL_NUM; p++) begin
        edgeModel[p] = windowEdge(firstPeak(p));
    end
endtask

// off-window samples never reach the histogram
task automatic modelFine();
    int p;
    int offset;
    clearHist();
    for (int i = 0; i < PASS_LEN; i++) begin
        p = samplePixel(i);
        offset = int'(fineSamples[i]) - int'(edgeModel[p]);
        if (offset >= 0 && offset < BIN_NUM) begin
            addHit(p, offset);
        end
    end
    for (int q = 0; q < PIXEL_NUM; q++) begin
        timeModel[q] = edgeModel[q] + Np'(firstPeak(q));
    end
endtask

`endif

// File: bench/sifhTb.sv
//**************************************************
// SiFH testbench
// seeded random frames through coarse and fine
// passes, checked against the reference model
//**************************************************

`timescale 1ns/1ps

module sifhTb import sifhCfgPkg::*, sifhTypesPkg::*;;

    logic                    clk;
    logic                    combin_res;
    logic                    wrEn;
    logic [Np-1:0]           data;
    logic                    busy;
    logic [PIXEL_NUM*Np-1:0] peakTimes;
    logic                    resultValid;

    // bookkeeping
    int checkCount;
    int errorCount;
    int testStart;
    int cycleCount;

    // per-pixel stimulus shape
    int centres [PIXEL_NUM];
    int binA [PIXEL_NUM];
    int binB [PIXEL_NUM];

    `include "sifhModel.svh"

    localparam logic [31:0] SEED = 32'hc799;
    localparam int RESET_CYCLES = 16;
    localparam int RAND_FRAMES = 5;
    // random frames, four directed, aborted plus clean frame
    localparam int FRAME_NUM = RAND_FRAMES + 6;
    localparam int SCAN_CYCLES = PIXEL_NUM * BIN_NUM + 6;
    localparam int TIMEOUT_CYCLES = FRAME_NUM * 2 * (PASS_LEN + SCAN_CYCLES) * 2
        + 4 * RESET_CYCLES;
    localparam int COARSE_SPAN = 2 ** (Np - Nb);

    // stimulus shapes
    localparam int MODE_CLUSTER = 0;
    localparam int MODE_LOW = 1;
    localparam int MODE_HIGH = 2;
    localparam int MODE_REJECT = 3;
    localparam int MODE_TIE = 4;

    sifhTop i_dut (
        .clk(clk), .combin_res(combin_res), .wrEn(wrEn), .data(data),
        .busy(busy), .peakTimes(peakTimes), .resultValid(resultValid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //**************************************************
    // stimulus generation
    //**************************************************

    // centre plus uniform jitter, held inside the code range
    function automatic logic [Np-1:0] nearTime(input int centre, input int spread);
        int v;
        v = centre + int'($urandom % (2 * spread + 1)) - spread;
        if (v < 0) begin
            v = 0;
        end
        if (v > 2 ** Np - 1) begin
            v = 2 ** Np - 1;
        end
        return Np'(v);
    endfunction

    // any code below the edge, or above the window when the edge is low
    function automatic logic [Np-1:0] outsideWindow(input int lo);
        if (lo >= BIN_NUM) begin
            return Np'($urandom % lo);
        end else begin
            return Np'(lo + BIN_NUM + int'($urandom % (2 ** Np - lo - BIN_NUM)));
        end
    endfunction

    task automatic fillCoarse(input int mode);
        int p;
        int bin;
        int spread;
        spread = (mode == MODE_LOW || mode == MODE_HIGH) ? 3 : 6;
        for (int q = 0; q < PIXEL_NUM; q++) begin
            case (mode)
                MODE_LOW: centres[q] = 3 + int'($urandom % 10);
                MODE_HIGH: centres[q] = 243 + int'($urandom % 10);
                default: centres[q] = int'($urandom % 2 ** Np);
            endcase
            // two distinct bins for the tie frames
            binA[q] = int'($urandom % BIN_NUM);
            binB[q] = (binA[q] + 1 + int'($urandom % (BIN_NUM - 1))) % BIN_NUM;
        end
        for (int i = 0; i < PASS_LEN; i++) begin
            p = samplePixel(i);
            if (mode == MODE_TIE) begin
                // even and odd samples split evenly
                bin = (i % 2 == 0) ? binA[p] : binB[p];
                coarseSamples[i] = Np'(bin * COARSE_SPAN + int'($urandom % COARSE_SPAN));
            end else begin
                coarseSamples[i] = nearTime(centres[p], spread);
            end
        end
    endtask

    // needs the coarse edges from the model
    task automatic fillFine(input int mode);
        int p;
        int lo;
        for (int i = 0; i < PASS_LEN; i++) begin
            p = samplePixel(i);
            lo = int'(edgeModel[p]);
            if (mode == MODE_TIE && p == PIXEL_NUM - 1) begin
                fineSamples[i] = outsideWindow(lo);
            end else if (mode == MODE_TIE) begin
                fineSamples[i] = Np'(lo + ((i % 2 == 0) ? binA[p] : binB[p]));
            end else if (mode == MODE_REJECT && $urandom % 4 != 0) begin
                fineSamples[i] = Np'($urandom % 2 ** Np);
            end else begin
                fineSamples[i] = nearTime(centres[p], 4);
            end
        end
    endtask

    //**************************************************
    // drivers and checks
    //**************************************************

    // one sample per cycle, held off while busy
    task automatic runPass(input bit fine, input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            while (busy) begin
                wrEn = 1'b0;
                @(negedge clk);
            end
            wrEn = 1'b1;
            data = fine ? fineSamples[i] : coarseSamples[i];
        end
        @(negedge clk);
        wrEn = 1'b0;
    endtask

    task automatic applyReset(input int cycles);
        @(negedge clk);
        combin_res = 1'b0;
        wrEn = 1'b0;
        repeat (cycles) @(negedge clk);
        combin_res = 1'b1;
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checkCount++;
        assert (got === exp) else begin
            errorCount++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    // pulse is high across the falling edge
    task automatic waitResult();
        while (resultValid !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    task automatic checkFrame();
        for (int p = 0; p < PIXEL_NUM; p++) begin
            checkValue($sformatf("peakTimes[%0d]", p),
                32'(peakTimes[p*Np +: Np]), 32'(timeModel[p]));
        end
    endtask

    task automatic runFrame(input int mode);
        fillCoarse(mode);
        modelCoarse();
        runPass(1'b0, PASS_LEN);
        fillFine(mode);
        modelFine();
        runPass(1'b1, PASS_LEN);
        waitResult();
        checkFrame();
    endtask

    task automatic startTest();
        testStart = errorCount;
    endtask

    task automatic endTest(input string name);
        int errs;
        errs = errorCount - testStart;
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d mismatches", name, errs);
        end
    endtask

    //**************************************************
    // test sequence
    //**************************************************

    initial begin
        void'($urandom(SEED));
        checkCount = 0;
        errorCount = 0;
        testStart = 0;
        combin_res = 1'b0;
        wrEn = 1'b0;
        data = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        combin_res = 1'b1;

        startTest();
        repeat (RAND_FRAMES) runFrame(MODE_CLUSTER);
        endTest("clustered frames");

        startTest();
        runFrame(MODE_LOW);
        endTest("low edge clamp");

        startTest();
        runFrame(MODE_HIGH);
        endTest("high edge clamp");

        startTest();
        runFrame(MODE_REJECT);
        endTest("out-of-window rejection");

        startTest();
        runFrame(MODE_TIE);
        endTest("ties and empty window");

        // abort a fine pass part way
        startTest();
        fillCoarse(MODE_CLUSTER);
        modelCoarse();
        runPass(1'b0, PASS_LEN);
        fillFine(MODE_CLUSTER);
        runPass(1'b1, PASS_LEN / 3);
        applyReset(RESET_CYCLES);
        @(negedge clk);
        checkValue("busy", 32'(busy), 32'd0);
        checkValue("resultValid", 32'(resultValid), 32'd0);
        checkValue("peakTimes", 32'(peakTimes), 32'd0);
        runFrame(MODE_CLUSTER);
        endTest("reset mid-frame");

        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        cycleCount = 0;
        while (cycleCount < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout after %0d cycles, the DUT never delivered a result", cycleCount);
        $display("Test failed");
        $finish;
    end

endmodule

// File: sifhPeak.f
+incdir+bench
source/sifhCfgPkg.sv
source/sifhTypesPkg.sv
source/sampleFilter.sv
source/histBuilder.sv
source/peakScanner.sv
source/windowCalc.sv
source/frameSequencer.sv
source/sifhTop.sv
bench/sifhTb.sv

// File: Makefile
# Verilator flow for the two-pass peak finder
# override any variable on the command line, e.g. make sim LOG=run1.log

VERILATOR ?= verilator
TOP       ?= sifhTb
FLIST     ?= sifhPeak.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --assert --timing -Wno-fatal
PASS_MSG  ?= Test passed

SOURCES := $(wildcard source/*.sv bench/*.sv bench/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(BUILD)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD)

# the log decides, not the exit code of the binary
sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
